// File: Bender.yml
package:
  name: muldiv_unit

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/muldiv_pkg.sv
      - rtl/mulDivCtrl.sv
      - rtl/signedMultiplier.sv
      - rtl/seqDivider.sv
      - rtl/hiLoReg.sv
      - rtl/mulDivUnit.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/mulDivUnit_assert.sv
      - sim/mulDivUnit_tb.sv

// File: rtl/hiLoReg.sv
`timescale 1ns/1ps
`include "muldiv_defs.svh"

module hiLoReg import muldiv_pkg::*; (
	input  logic      clk,
	input  logic      reset_i,
	input  logic      we_i,
	input  hiLoSel_e  sel_i,   // full word, HI only, LO only
	input  hiLoWord_u d_i,
	output hiLoWord_u q_o
);

	hiLoWord_u nextQ;

	//////////////////////////////
	// half select
	//////////////////////////////
	always_comb begin
		nextQ = q_o; // untouched half keeps its value
		case (sel_i)
			selHi: nextQ.pair.hi = d_i.pair.hi;    // MTHI
			selLo: nextQ.pair.lo = d_i.pair.lo;    // MTLO
			default: nextQ = d_i;                  // product or rem/quot
		endcase
	end

	// architectural state, cleared on reset
	always_ff @(posedge clk) begin
		if (reset_i)
			q_o <= '0;
		else if (we_i)
			q_o <= nextQ;
	end

endmodule

// File: rtl/mulDivCtrl.sv
`timescale 1ns/1ps
`include "muldiv_defs.svh"

module mulDivCtrl import muldiv_pkg::*; (
	input  logic                 clk,
	input  logic                 reset_i,
	input  logic                 cmdValid_i,
	input  mdCmd_t               cmd_i,
	input  logic                 annul_i,      // flush, kills a divide in flight
	input  logic                 mulDone_i,
	input  hiLoWord_u            mulProduct_i,
	input  logic                 divReady_i,
	input  hiLoWord_u            divResult_i,
	input  hiLoWord_u            hiLoQ_i,
	output logic                 mulStart_o,
	output logic                 mulSigned_o,
	output logic                 divStart_o,
	output logic                 divSigned_o,
	output logic [`MD_WIDTH-1:0] opA_o,
	output logic [`MD_WIDTH-1:0] opB_o,
	output logic                 hiLoWe_o,
	output hiLoSel_e             hiLoSel_o,
	output hiLoWord_u            hiLoD_o,
	output logic                 divAnnul_o,
	output logic                 done_o,
	output logic                 divZero_o,
	output logic [`MD_WIDTH-1:0] result_o
);

	typedef enum logic [1:0] {stIdle, stMulWait, stDivWait, stFinish} ctrlState_e;

	ctrlState_e state;
	mdCmd_t     cmdReg;       // latched on accept
	logic       waitRelease;  // host must drop cmdValid_i before the next accept
	logic       zeroPend;     // divide with zero divisor, no divider run
	logic       accept;
	logic       newIsMul;
	logic       newIsDiv;

	assign accept   = (state == stIdle) && cmdValid_i && !waitRelease;
	assign newIsMul = (cmd_i.op == opMult) || (cmd_i.op == opMultu);
	assign newIsDiv = (cmd_i.op == opDiv) || (cmd_i.op == opDivu);

	// operands straight from the latch, stable while start pulses
	assign opA_o       = cmdReg.srcA;
	assign opB_o       = cmdReg.srcB;
	assign mulSigned_o = (cmdReg.op == opMult);
	assign divSigned_o = (cmdReg.op == opDiv);
	assign divAnnul_o  = annul_i && (state == stDivWait);

	//////////////////////////////
	// FSM
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset_i) begin
			state       <= stIdle;
			mulStart_o  <= 1'b0;
			divStart_o  <= 1'b0;
			done_o      <= 1'b0;
			divZero_o   <= 1'b0;
			waitRelease <= 1'b0;
			zeroPend    <= 1'b0;
		end else begin
			mulStart_o <= 1'b0; // pulses by default
			divStart_o <= 1'b0;
			done_o     <= 1'b0;
			divZero_o  <= 1'b0;
			if (!cmdValid_i)
				waitRelease <= 1'b0;
			case (state)
				stIdle: if (accept) begin
					zeroPend <= newIsDiv && (cmd_i.srcB == '0);
					if (newIsMul) begin
						state      <= stMulWait;
						mulStart_o <= 1'b1;
					end else if (newIsDiv && (cmd_i.srcB != '0)) begin
						state      <= stDivWait;
						divStart_o <= 1'b1;
					end else begin
						state <= stFinish; // moves and div by zero
					end
				end
				stMulWait: if (mulDone_i) begin
					done_o      <= 1'b1;
					waitRelease <= 1'b1;
					state       <= stIdle;
				end
				stDivWait: begin
					if (annul_i) begin
						waitRelease <= 1'b1; // aborted, no done
						state       <= stIdle;
					end else if (divReady_i) begin
						done_o      <= 1'b1;
						waitRelease <= 1'b1;
						state       <= stIdle;
					end
				end
				default: begin // stFinish
					done_o      <= 1'b1;
					divZero_o   <= zeroPend;
					waitRelease <= 1'b1;
					state       <= stIdle;
				end
			endcase
		end
	end

	// command latch and move-from result
	always_ff @(posedge clk) begin
		if (accept)
			cmdReg <= cmd_i;
		result_o <= '0; // zero for everything but MFHI/MFLO
		if (state == stFinish) begin
			if (cmdReg.op == opMfhi)
				result_o <= hiLoQ_i.pair.hi;
			else if (cmdReg.op == opMflo)
				result_o <= hiLoQ_i.pair.lo;
		end
	end

	//////////////////////////////
	// HI/LO write routing
	//////////////////////////////
	always_comb begin
		hiLoWe_o          = 1'b0;
		hiLoSel_o         = selFull;
		hiLoD_o.pair.hi   = cmdReg.srcA; // move data on both halves
		hiLoD_o.pair.lo   = cmdReg.srcA;
		case (state)
			stMulWait: begin
				hiLoWe_o = mulDone_i;
				hiLoD_o  = mulProduct_i;
			end
			stDivWait: begin
				hiLoWe_o = divReady_i && !annul_i; // annul wins over a late ready
				hiLoD_o  = divResult_i;
			end
			stFinish: begin
				hiLoWe_o  = (cmdReg.op == opMthi) || (cmdReg.op == opMtlo);
				hiLoSel_o = (cmdReg.op == opMthi) ? selHi : selLo;
			end
			default: ;
		endcase
	end

endmodule

// File: rtl/mulDivUnit.sv
`timescale 1ns/1ps
`include "muldiv_defs.svh"

module mulDivUnit import muldiv_pkg::*; (
	input  logic                 clk,
	input  logic                 reset_i,
	input  logic                 cmdValid_i,
	input  mdCmd_t               cmd_i,
	input  logic                 annul_i,
	output logic                 done_o,
	output logic                 divZero_o,
	output logic [`MD_WIDTH-1:0] result_o
);

	//////////////////////////////
	// internal links
	//////////////////////////////
	logic                 mulStart;
	logic                 mulSigned;
	logic                 mulDone;
	hiLoWord_u            mulProduct;
	logic                 divStart;
	logic                 divSigned;
	logic                 divAnnul;
	logic                 divReady;
	hiLoWord_u            divResult;
	logic [`MD_WIDTH-1:0] opA;
	logic [`MD_WIDTH-1:0] opB;
	logic                 hiLoWe;
	hiLoSel_e             hiLoSel;
	hiLoWord_u            hiLoD;
	hiLoWord_u            hiLoQ;

	mulDivCtrl ctrl (
		.clk(clk), .reset_i(reset_i), .cmdValid_i(cmdValid_i), .cmd_i(cmd_i),
		.annul_i(annul_i), .mulDone_i(mulDone), .mulProduct_i(mulProduct),
		.divReady_i(divReady), .divResult_i(divResult), .hiLoQ_i(hiLoQ),
		.mulStart_o(mulStart), .mulSigned_o(mulSigned), .divStart_o(divStart),
		.divSigned_o(divSigned), .opA_o(opA), .opB_o(opB), .hiLoWe_o(hiLoWe),
		.hiLoSel_o(hiLoSel), .hiLoD_o(hiLoD), .divAnnul_o(divAnnul),
		.done_o(done_o), .divZero_o(divZero_o), .result_o(result_o)
	);

	signedMultiplier mult (
		.clk(clk), .reset_i(reset_i), .start_i(mulStart), .signed_i(mulSigned),
		.a_i(opA), .b_i(opB), .product_o(mulProduct), .done_o(mulDone)
	);

	// opA dividend, opB divisor
	seqDivider div (
		.clk(clk), .reset_i(reset_i), .start_i(divStart), .signed_i(divSigned),
		.annul_i(divAnnul), .dividend_i(opA), .divisor_i(opB),
		.result_o(divResult), .ready_o(divReady)
	);

	hiLoReg hiLo (
		.clk(clk), .reset_i(reset_i), .we_i(hiLoWe), .sel_i(hiLoSel),
		.d_i(hiLoD), .q_o(hiLoQ)
	);

endmodule

// File: rtl/muldiv_defs.svh
`ifndef MULDIV_DEFS_SVH
`define MULDIV_DEFS_SVH

//////////////////////////////
// data path
//////////////////////////////

`define MD_WIDTH 32 // one HI or LO word

//////////////////////////////
// command op codes
//////////////////////////////

`define MD_OP_BITS 3

`define MD_OP_MULT  3'd0 // signed product into HI/LO
`define MD_OP_MULTU 3'd1
`define MD_OP_DIV   3'd2 // quotient to LO, remainder to HI
`define MD_OP_DIVU  3'd3
`define MD_OP_MTHI  3'd4 // srcA into HI
`define MD_OP_MTLO  3'd5 // srcA into LO
`define MD_OP_MFHI  3'd6 // HI on result
`define MD_OP_MFLO  3'd7 // LO on result

// one restoring step per quotient bit
`define MD_DIV_STEPS `MD_WIDTH

`endif

// File: rtl/muldiv_pkg.sv
package muldiv_pkg;

`include "muldiv_defs.svh"

	// command op, codes shared with the test data
	typedef enum logic [`MD_OP_BITS-1:0] {
		opMult  = `MD_OP_MULT,
		opMultu = `MD_OP_MULTU,
		opDiv   = `MD_OP_DIV,
		opDivu  = `MD_OP_DIVU,
		opMthi  = `MD_OP_MTHI,
		opMtlo  = `MD_OP_MTLO,
		opMfhi  = `MD_OP_MFHI,
		opMflo  = `MD_OP_MFLO
	} mdOp_e;

	// one host command, 67 bits
	typedef struct packed {
		mdOp_e                 op;
		logic [`MD_WIDTH-1:0]  srcA; // dividend / multiplicand / move data
		logic [`MD_WIDTH-1:0]  srcB; // divisor / multiplier
	} mdCmd_t;

	typedef struct packed {
		logic [`MD_WIDTH-1:0]  hi;
		logic [`MD_WIDTH-1:0]  lo;
	} hiLoPair_t;

	// full = product as one word, pair = rem/quot or move halves
	typedef union packed {
		logic [2*`MD_WIDTH-1:0] full;
		hiLoPair_t              pair;
	} hiLoWord_u;

	// which half a HI/LO write touches
	typedef enum logic [1:0] {selFull, selHi, selLo} hiLoSel_e;

endpackage

// File: rtl/seqDivider.sv
`timescale 1ns/1ps
`include "muldiv_defs.svh"

module seqDivider import muldiv_pkg::*; (
	input  logic                 clk,
	input  logic                 reset_i,
	input  logic                 start_i,
	input  logic                 signed_i,   // DIV vs DIVU
	input  logic                 annul_i,    // back to idle from any step
	input  logic [`MD_WIDTH-1:0] dividend_i,
	input  logic [`MD_WIDTH-1:0] divisor_i,  // never zero, filtered upstream
	output hiLoWord_u            result_o,   // hi = remainder, lo = quotient
	output logic                 ready_o     // one cycle, low while busy
);

	localparam int W       = `MD_WIDTH;
	localparam int CntBits = $clog2(`MD_DIV_STEPS);

	typedef enum logic [1:0] {divIdle, divRun, divFix} divState_e;

	divState_e          state;
	logic [CntBits-1:0] stepCnt;
	logic [W-1:0]       remReg;     // partial remainder
	logic [W-1:0]       quoReg;     // dividend shifting out, quotient shifting in
	logic [W-1:0]       dvsReg;     // divisor magnitude
	logic               negQuo;
	logic               negRem;
	logic [W-1:0]       dividendMag;
	logic [W-1:0]       divisorMag;
	logic [W:0]         shifted;
	logic [W+1:0]       trial;

	assign dividendMag = (signed_i && dividend_i[W-1]) ? -dividend_i : dividend_i;
	assign divisorMag  = (signed_i && divisor_i[W-1]) ? -divisor_i : divisor_i;

	//////////////////////////////
	// one restoring step
	//////////////////////////////
	assign shifted = {remReg, quoReg[W-1]};               // bring down next dividend bit
	assign trial   = {1'b0, shifted} - {2'b00, dvsReg};   // msb set means borrow

	// control state
	always_ff @(posedge clk) begin
		if (reset_i) begin
			state   <= divIdle;
			stepCnt <= '0;
			ready_o <= 1'b0;
		end else begin
			ready_o <= 1'b0;
			if (annul_i) begin
				state <= divIdle; // drop the run, result untouched
			end else begin
				case (state)
					divIdle: if (start_i) begin
						state   <= divRun;
						stepCnt <= '0;
					end
					divRun: begin
						stepCnt <= stepCnt + 1'b1;
						if (stepCnt == CntBits'(`MD_DIV_STEPS - 1))
							state <= divFix;
					end
					default: begin // divFix
						ready_o <= 1'b1;
						state   <= divIdle;
					end
				endcase
			end
		end
	end

	// datapath registers
	always_ff @(posedge clk) begin
		case (state)
			divIdle: if (start_i) begin
				remReg <= '0;
				quoReg <= dividendMag;
				dvsReg <= divisorMag;
				negQuo <= signed_i && (dividend_i[W-1] ^ divisor_i[W-1]);
				negRem <= signed_i && dividend_i[W-1]; // remainder follows dividend
			end
			divRun: begin
				if (!trial[W+1])
					remReg <= trial[W-1:0];   // subtract fits
				else
					remReg <= shifted[W-1:0]; // restore
				quoReg <= {quoReg[W-2:0], ~trial[W+1]};
			end
			default: begin
				//////////////////////////////
				// sign fix, truncation toward zero
				//////////////////////////////
				result_o.pair.lo <= negQuo ? -quoReg : quoReg;
				result_o.pair.hi <= negRem ? -remReg : remReg;
			end
		endcase
	end

endmodule

// File: rtl/signedMultiplier.sv
`timescale 1ns/1ps
`include "muldiv_defs.svh"

module signedMultiplier import muldiv_pkg::*; (
	input  logic                 clk,
	input  logic                 reset_i,
	input  logic                 start_i,
	input  logic                 signed_i,  // MULT vs MULTU
	input  logic [`MD_WIDTH-1:0] a_i,
	input  logic [`MD_WIDTH-1:0] b_i,
	output hiLoWord_u            product_o,
	output logic                 done_o     // one cycle after start
);

	localparam int W = `MD_WIDTH;

	logic [W-1:0]   magA;
	logic [W-1:0]   magB;
	logic [2*W-1:0] magProd;
	logic           negProd;

	//////////////////////////////
	// magnitude correction
	//////////////////////////////
	assign magA    = (signed_i && a_i[W-1]) ? -a_i : a_i; // -2^31 stays 2^31 unsigned
	assign magB    = (signed_i && b_i[W-1]) ? -b_i : b_i;
	assign negProd = signed_i && (a_i[W-1] ^ b_i[W-1]);

	// unsigned W x W, zero extended first
	assign magProd = {{W{1'b0}}, magA} * {{W{1'b0}}, magB};

	// product register, loaded on start only
	always_ff @(posedge clk) begin
		if (start_i)
			product_o.full <= negProd ? -magProd : magProd;
	end

	always_ff @(posedge clk) begin
		if (reset_i)
			done_o <= 1'b0;
		else
			done_o <= start_i; // single stage
	end

endmodule

// File: sim.f
+incdir+rtl
rtl/muldiv_pkg.sv
rtl/mulDivCtrl.sv
rtl/signedMultiplier.sv
rtl/seqDivider.sv
rtl/hiLoReg.sv
rtl/mulDivUnit.sv
sim/mulDivUnit_assert.sv
sim/mulDivUnit_tb.sv

// File: sim/mulDivUnit_assert.sv
`timescale 1ns/1ps

module mulDivUnit_assert (
	input logic clk,
	input logic reset_i,
	input logic done_i,
	input logic divZero_i
);

	int assertFails = 0; // bumped by every failing property

	//////////////////////////////
	// top-level handshake
	//////////////////////////////

	// single-cycle done pulse
	doneOnePulse: assert property (@(posedge clk) disable iff (reset_i) done_i |=> !done_i)
		else begin
			$error("done_o stayed high for more than one cycle");
			assertFails++;
		end

	// quiet in reset and the cycle after
	doneQuietReset: assert property (@(posedge clk) reset_i |=> !done_i)
		else begin
			$error("done_o high during or right after reset");
			assertFails++;
		end

	zeroWithDone: assert property (@(posedge clk) disable iff (reset_i) divZero_i |-> done_i)
		else begin
			$error("divZero_o high without done_o"); // flag rides on done
			assertFails++;
		end

endmodule

bind mulDivUnit mulDivUnit_assert handshakeChk (
	.clk(clk), .reset_i(reset_i), .done_i(done_o), .divZero_i(divZero_o)
);

// File: sim/mulDivUnit_tb.sv
`timescale 1ns/1ps
`include "muldiv_defs.svh"

module mulDivUnit_tb import muldiv_pkg::*; ();

	localparam int MaxVec  = 64;
	localparam int Timeout = 60; // cycles per wait
	localparam int AnnulAt = 10; // cycles into the divide

	logic                 clk;
	logic                 reset_i;
	logic                 cmdValid_i;
	mdCmd_t               cmd_i;
	logic                 annul_i;
	logic                 done_o;
	logic                 divZero_o;
	logic [`MD_WIDTH-1:0] result_o;

	logic [31:0] vecMem [0:5*MaxVec-1]; // op, srcA, srcB, expected, annul
	int          passCnt;
	int          failCnt;

	mulDivUnit uut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// done_o sampled on falling edges, bounded
	task automatic waitDone(output bit seen, output int cycles);
		seen   = 1'b0;
		cycles = 0;
		while (!seen && cycles < Timeout) begin
			@(negedge clk);
			cycles++;
			seen = done_o;
		end
	endtask

	//////////////////////////////
	// one command from the file
	//////////////////////////////
	task automatic runVector(input int idx);
		mdCmd_t          cmd;
		logic [2:0]      opCode;
		logic [31:0]     expRes;
		logic            annul;
		logic            expZero;
		int              expLat;
		bit              seen;
		int              cycles;
		bit              ok;
		opCode   = vecMem[5*idx][`MD_OP_BITS-1:0];
		cmd.op   = mdOp_e'(opCode);
		cmd.srcA = vecMem[5*idx+1];
		cmd.srcB = vecMem[5*idx+2];
		expRes   = vecMem[5*idx+3];
		annul    = vecMem[5*idx+4][0];
		ok       = 1'b1;
		expZero  = (opCode == `MD_OP_DIV || opCode == `MD_OP_DIVU) && (cmd.srcB == '0);
		if (opCode == `MD_OP_MULT || opCode == `MD_OP_MULTU)
			expLat = 2;
		else if (expZero || opCode >= `MD_OP_MTHI)
			expLat = 1; // moves and zero divisor
		else
			expLat = 0; // divide, timeout only
		@(negedge clk);
		cmd_i      = cmd;
		cmdValid_i = 1'b1;
		if (annul) begin
			repeat (AnnulAt) @(negedge clk);
			annul_i = 1'b1; // one cycle flush
			@(negedge clk);
			annul_i    = 1'b0;
			cmdValid_i = 1'b0;
			waitDone(seen, cycles);
			assert (!seen) else begin
				$display("done_o came after an annulled divide");
				ok = 1'b0;
			end
		end else begin
			waitDone(seen, cycles);
			cmdValid_i = 1'b0; // falling edge after done_o
			assert (seen) else begin
				$display("timed out, no done_o within %0d cycles", Timeout);
				ok = 1'b0;
			end
			if (seen) begin
				assert (result_o == expRes) else begin
					$display("Mismatch result_o: got %h, expected %h", result_o, expRes);
					ok = 1'b0;
				end
				assert (divZero_o == expZero) else begin
					$display("Mismatch divZero_o: got %h, expected %h", divZero_o, expZero);
					ok = 1'b0;
				end
				assert (expLat == 0 || cycles - 1 == expLat) else begin
					$display("done_o came %0d cycles after accept instead of %0d",
						cycles - 1, expLat);
					ok = 1'b0;
				end
			end
		end
		if (ok)
			passCnt++;
		else
			failCnt++;
		$display("test %0d op %0d %h %h: %s", idx, opCode, cmd.srcA, cmd.srcB,
			ok ? "ok" : "failed");
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////
	initial begin
		int nVec;
		int gap;
		reset_i    = 1'b1;
		cmdValid_i = 1'b0;
		cmd_i      = '0;
		annul_i    = 1'b0;
		passCnt    = 0;
		failCnt    = 0;
		void'($urandom(32'h5680af9f)); // seeded once
		$readmemh("sim/muldiv_input.txt", vecMem);
		nVec = 0;
		while (nVec < MaxVec && !$isunknown(vecMem[5*nVec]))
			nVec++;
		repeat (5) @(negedge clk);
		reset_i = 1'b0;
		assert (nVec > 0) else begin
			$display("no test vectors were read from the input file");
			failCnt++;
		end
		for (int i = 0; i < nVec; i++) begin
			gap = $urandom % 4; // idle gap 0..3
			repeat (gap) @(negedge clk);
			runVector(i);
		end
		// bound handshake properties
		assert (uut.handshakeChk.assertFails == 0) else begin
			$display("handshake assertions failed %0d times", uut.handshakeChk.assertFails);
			failCnt++;
		end
		$display("%0d tests passed, %0d failed", passCnt, failCnt);
		if (failCnt == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: sim/muldiv_input.txt
// op srcA srcB expected annul, op 0 MULT 1 MULTU 2 DIV 3 DIVU 4 MTHI 5 MTLO 6 MFHI 7 MFLO
// expected is result_o with done_o, annul 1 flushes the divide midway
4 12345678 00000000 00000000 0
5 9abcdef0 00000000 00000000 0
6 00000000 00000000 12345678 0
4 cafef00d 00000000 00000000 0
6 00000000 00000000 cafef00d 0
7 00000000 00000000 9abcdef0 0
0 80000000 80000000 00000000 0
6 00000000 00000000 40000000 0
7 00000000 00000000 00000000 0
0 fffffffd 00012345 00000000 0
6 00000000 00000000 ffffffff 0
7 00000000 00000000 fffc9631 0
1 fffffffd 00012345 00000000 0
6 00000000 00000000 00012344 0
7 00000000 00000000 fffc9631 0
2 fffffff9 00000002 00000000 0
6 00000000 00000000 ffffffff 0
7 00000000 00000000 fffffffd 0
2 00000007 fffffffe 00000000 0
6 00000000 00000000 00000001 0
7 00000000 00000000 fffffffd 0
3 fffffff9 00000002 00000000 0
7 00000000 00000000 7ffffffc 0
2 12345678 00000000 00000000 0
6 00000000 00000000 00000001 0
7 00000000 00000000 7ffffffc 0
2 00000064 00000007 00000000 1
6 00000000 00000000 00000001 0
7 00000000 00000000 7ffffffc 0
